// File: rtl/tk1_pkg.sv
// tk1 control core shared definitions
// Bus address map, identity words, memory map bounds and the structs
// that carry bus, register select, CPU access and window state

`default_nettype none

package tk1_pkg;

  // --------------------------------------------------------------------------
  // Register address map
  // --------------------------------------------------------------------------
  localparam logic [7:0] ADDR_NAME0         = 8'h00;
  localparam logic [7:0] ADDR_NAME1         = 8'h01;
  localparam logic [7:0] ADDR_VERSION       = 8'h02;
  localparam logic [7:0] ADDR_SYSTEM_MODE   = 8'h08;
  localparam logic [7:0] ADDR_LED           = 8'h09;
  localparam logic [7:0] ADDR_GPIO          = 8'h0a;
  localparam logic [7:0] ADDR_APP_START     = 8'h0c;
  localparam logic [7:0] ADDR_APP_SIZE      = 8'h0d;
  localparam logic [7:0] ADDR_SYSCALL       = 8'h12;
  localparam logic [7:0] ADDR_CDI_FIRST     = 8'h20;
  localparam logic [7:0] ADDR_CDI_LAST      = 8'h27;
  localparam logic [7:0] ADDR_CPU_MON_CTRL  = 8'h60;
  localparam logic [7:0] ADDR_CPU_MON_FIRST = 8'h61;
  localparam logic [7:0] ADDR_CPU_MON_LAST  = 8'h62;
  localparam logic [7:0] ADDR_SYSTEM_RESET  = 8'h70;

  // ASCII "tk1 " and "mkdf"
  localparam logic [31:0] TK1_NAME0   = 32'h746b3120;
  localparam logic [31:0] TK1_NAME1   = 32'h6d6b6466;
  localparam logic [31:0] TK1_VERSION = 32'h00000005;

  // --------------------------------------------------------------------------
  // Memory map
  // --------------------------------------------------------------------------
  localparam logic [31:0] FW_RAM_FIRST = 32'hd0000000;
  localparam logic [31:0] FW_RAM_LAST  = 32'hd00007ff;
  localparam logic [31:0] FW_ROM_LAST  = 32'h00001fff;
  // Outside physical memory, traps if ever fetched
  localparam logic [31:0] ILLEGAL_ADDR = 32'h4f000000;

  // Bit positions in the LED and GPIO words
  localparam int LED_R_BIT = 2;
  localparam int LED_G_BIT = 1;
  localparam int LED_B_BIT = 0;
  localparam int GPIO1_BIT = 0;
  localparam int GPIO2_BIT = 1;
  localparam int GPIO3_BIT = 2;
  localparam int GPIO4_BIT = 3;

  localparam logic [2:0] LED_RESET = 3'b110;
  localparam int TRAP_BLINK_BITS   = 24;
  localparam int CDI_WORDS         = 8;

  typedef enum logic [3:0] {
    REG_NONE,
    REG_NAME0,
    REG_NAME1,
    REG_VERSION,
    REG_SYSTEM_MODE,
    REG_LED,
    REG_GPIO,
    REG_APP_START,
    REG_APP_SIZE,
    REG_SYSCALL,
    REG_CDI,
    REG_CPU_MON_CTRL,
    REG_CPU_MON_FIRST,
    REG_CPU_MON_LAST,
    REG_SYSTEM_RESET
  } tk1_reg_id_t;

  typedef struct packed {
    logic        cs;
    logic        we;
    logic [7:0]  address;
    logic [31:0] write_data;
  } tk1_bus_req_t;

  typedef struct packed {
    logic        we;
    tk1_reg_id_t id;
    logic [2:0]  cdi_idx;
  } tk1_reg_sel_t;

  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
  } tk1_cpu_access_t;

  // Data-only region, fetches inside it trap once enabled
  typedef struct packed {
    logic        en;
    logic [31:0] first;
    logic [31:0] last;
  } tk1_exec_window_t;

endpackage

`default_nettype wire

// File: rtl/tk1_addr_decode.sv
// tk1 bus address decode
// Maps a bus request onto a register id, with the CDI range folded
// into one id plus a word index

`timescale 1ns/1ps
`default_nettype none

module tk1_addr_decode (
  input  wire tk1_pkg::tk1_bus_req_t bus_req,
  output tk1_pkg::tk1_reg_sel_t      reg_sel
);

  logic in_cdi;

  assign in_cdi = (bus_req.address >= tk1_pkg::ADDR_CDI_FIRST) &&
                  (bus_req.address <= tk1_pkg::ADDR_CDI_LAST);

  always_comb begin
    reg_sel.we = bus_req.cs && bus_req.we;
    // CDI block is aligned, so the low bits are the word index
    reg_sel.cdi_idx = bus_req.address[2:0];

    case (bus_req.address)
      tk1_pkg::ADDR_NAME0:         reg_sel.id = tk1_pkg::REG_NAME0;
      tk1_pkg::ADDR_NAME1:         reg_sel.id = tk1_pkg::REG_NAME1;
      tk1_pkg::ADDR_VERSION:       reg_sel.id = tk1_pkg::REG_VERSION;
      tk1_pkg::ADDR_SYSTEM_MODE:   reg_sel.id = tk1_pkg::REG_SYSTEM_MODE;
      tk1_pkg::ADDR_LED:           reg_sel.id = tk1_pkg::REG_LED;
      tk1_pkg::ADDR_GPIO:          reg_sel.id = tk1_pkg::REG_GPIO;
      tk1_pkg::ADDR_APP_START:     reg_sel.id = tk1_pkg::REG_APP_START;
      tk1_pkg::ADDR_APP_SIZE:      reg_sel.id = tk1_pkg::REG_APP_SIZE;
      tk1_pkg::ADDR_SYSCALL:       reg_sel.id = tk1_pkg::REG_SYSCALL;
      tk1_pkg::ADDR_CPU_MON_CTRL:  reg_sel.id = tk1_pkg::REG_CPU_MON_CTRL;
      tk1_pkg::ADDR_CPU_MON_FIRST: reg_sel.id = tk1_pkg::REG_CPU_MON_FIRST;
      tk1_pkg::ADDR_CPU_MON_LAST:  reg_sel.id = tk1_pkg::REG_CPU_MON_LAST;
      tk1_pkg::ADDR_SYSTEM_RESET:  reg_sel.id = tk1_pkg::REG_SYSTEM_RESET;
      default: begin
        if (in_cdi) begin
          reg_sel.id = tk1_pkg::REG_CDI;
        end else begin
          reg_sel.id = tk1_pkg::REG_NONE;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/tk1_ctrl_regs.sv
// tk1 register bank
// Holds the control registers, blocks firmware-only writes in system
// mode, locks the execution window once enabled and muxes read data

`timescale 1ns/1ps
`default_nettype none

module tk1_ctrl_regs (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire tk1_pkg::tk1_bus_req_t bus_req,
  input  wire tk1_pkg::tk1_reg_sel_t reg_sel,
  input  wire                        system_mode,
  input  wire [1:0]                  gpio_in,
  output logic [31:0]                read_data,
  output logic                       ready,
  output tk1_pkg::tk1_exec_window_t  exec_window,
  output logic [31:0]                syscall_addr,
  output logic [2:0]                 led_value,
  output logic [1:0]                 gpio_out,
  output logic                       system_reset
);

  logic [2:0]  led_reg;
  logic [1:0]  gpio_out_reg;
  logic [31:0] app_start_reg;
  logic [31:0] app_size_reg;
  logic [31:0] syscall_reg;
  logic [31:0] cdi_mem [tk1_pkg::CDI_WORDS];
  logic        win_en_reg;
  logic [31:0] win_first_reg;
  logic [31:0] win_last_reg;
  logic        system_reset_reg;

  // --------------------------------------------------------------------------
  // Register writes
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_reg          <= tk1_pkg::LED_RESET;
      gpio_out_reg     <= 2'b00;
      app_start_reg    <= '0;
      app_size_reg     <= '0;
      syscall_reg      <= tk1_pkg::ILLEGAL_ADDR;
      win_en_reg       <= 1'b0;
      win_first_reg    <= '0;
      win_last_reg     <= '0;
      system_reset_reg <= 1'b0;
      for (int i = 0; i < tk1_pkg::CDI_WORDS; i++) begin
        cdi_mem[i] <= '0;
      end
    end else begin
      system_reset_reg <= reg_sel.we && (reg_sel.id == tk1_pkg::REG_SYSTEM_RESET);

      if (reg_sel.we) begin
        case (reg_sel.id)
          tk1_pkg::REG_LED: led_reg <= bus_req.write_data[2:0];
          tk1_pkg::REG_GPIO: begin
            gpio_out_reg <= {bus_req.write_data[tk1_pkg::GPIO4_BIT],
                             bus_req.write_data[tk1_pkg::GPIO3_BIT]};
          end
          // Firmware-owned values, frozen once the app runs
          tk1_pkg::REG_APP_START: if (!system_mode) app_start_reg <= bus_req.write_data;
          tk1_pkg::REG_APP_SIZE:  if (!system_mode) app_size_reg <= bus_req.write_data;
          tk1_pkg::REG_SYSCALL:   if (!system_mode) syscall_reg <= bus_req.write_data;
          tk1_pkg::REG_CDI: begin
            if (!system_mode) begin
              cdi_mem[reg_sel.cdi_idx] <= bus_req.write_data;
            end
          end
          // Enable is sticky and locks the bounds
          tk1_pkg::REG_CPU_MON_CTRL:  win_en_reg <= 1'b1;
          tk1_pkg::REG_CPU_MON_FIRST: if (!win_en_reg) win_first_reg <= bus_req.write_data;
          tk1_pkg::REG_CPU_MON_LAST:  if (!win_en_reg) win_last_reg <= bus_req.write_data;
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Combinational read mux that answers only reads on the bus
  // --------------------------------------------------------------------------
  always_comb begin
    read_data = '0;
    if (bus_req.cs && !bus_req.we) begin
      case (reg_sel.id)
        tk1_pkg::REG_NAME0:       read_data = tk1_pkg::TK1_NAME0;
        tk1_pkg::REG_NAME1:       read_data = tk1_pkg::TK1_NAME1;
        tk1_pkg::REG_VERSION:     read_data = tk1_pkg::TK1_VERSION;
        tk1_pkg::REG_SYSTEM_MODE: read_data = {32{system_mode}};
        tk1_pkg::REG_LED:         read_data = {29'h0, led_reg};
        tk1_pkg::REG_GPIO: begin
          read_data[tk1_pkg::GPIO4_BIT] = gpio_out_reg[1];
          read_data[tk1_pkg::GPIO3_BIT] = gpio_out_reg[0];
          read_data[tk1_pkg::GPIO2_BIT] = gpio_in[1];
          read_data[tk1_pkg::GPIO1_BIT] = gpio_in[0];
        end
        tk1_pkg::REG_APP_START:     read_data = app_start_reg;
        tk1_pkg::REG_APP_SIZE:      read_data = app_size_reg;
        tk1_pkg::REG_SYSCALL:       read_data = syscall_reg;
        tk1_pkg::REG_CDI:           read_data = cdi_mem[reg_sel.cdi_idx];
        tk1_pkg::REG_CPU_MON_CTRL:  read_data = {31'h0, win_en_reg};
        tk1_pkg::REG_CPU_MON_FIRST: read_data = win_first_reg;
        tk1_pkg::REG_CPU_MON_LAST:  read_data = win_last_reg;
        default: read_data = '0;
      endcase
    end
  end

  assign ready        = bus_req.cs;
  assign exec_window  = '{en: win_en_reg, first: win_first_reg, last: win_last_reg};
  assign syscall_addr = syscall_reg;
  assign led_value    = led_reg;
  assign gpio_out     = gpio_out_reg;
  assign system_reset = system_reset_reg;

  // Single-cycle handshake with a quiet bus when idle
  assert property (@(posedge clk) (ready == bus_req.cs) && (ready || read_data == '0));

endmodule

`default_nettype wire

// File: rtl/tk1_cpu_monitor.sv
// tk1 CPU monitor
// Tracks system mode from instruction fetches and raises a sticky
// force_trap on illegal RAM accesses and forbidden fetches

`timescale 1ns/1ps
`default_nettype none

module tk1_cpu_monitor (
  input  wire                            clk,
  input  wire                            reset_n,
  input  wire tk1_pkg::tk1_cpu_access_t  cpu_access,
  input  wire tk1_pkg::tk1_exec_window_t exec_window,
  input  wire [31:0]                     syscall_addr,
  output logic                           system_mode,
  output logic                           force_trap
);

  logic fetch;
  logic mode_set;
  logic mode_clr;
  logic in_fw_ram;
  logic in_window;
  logic bad_ram_access;
  logic trap_set;

  logic system_mode_reg;
  logic force_trap_reg;

  assign fetch = cpu_access.valid && cpu_access.instr;

  // Leaving ROM enters system mode, calling the syscall entry leaves it
  assign mode_set = fetch && (cpu_access.addr > tk1_pkg::FW_ROM_LAST);
  assign mode_clr = fetch && (cpu_access.addr == syscall_addr);

  // --------------------------------------------------------------------------
  // Security checks
  // --------------------------------------------------------------------------
  // RAM lives at 0x4xxxxxxx, anything past its physical size is illegal
  assign bad_ram_access = cpu_access.valid && (cpu_access.addr[31:30] == 2'b01) &&
                          (|cpu_access.addr[29:17]);

  assign in_fw_ram = (cpu_access.addr >= tk1_pkg::FW_RAM_FIRST) &&
                     (cpu_access.addr <= tk1_pkg::FW_RAM_LAST);

  assign in_window = exec_window.en &&
                     (cpu_access.addr >= exec_window.first) &&
                     (cpu_access.addr <= exec_window.last);

  assign trap_set = bad_ram_access || (fetch && (in_fw_ram || in_window));

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      system_mode_reg <= 1'b0;
      force_trap_reg  <= 1'b0;
    end else begin
      if (mode_set) begin
        system_mode_reg <= 1'b1;
      end else if (mode_clr) begin
        system_mode_reg <= 1'b0;
      end

      if (trap_set) begin
        force_trap_reg <= 1'b1;
      end
    end
  end

  assign system_mode = system_mode_reg;
  assign force_trap  = force_trap_reg;

  // Once tripped, only a reset clears the trap
  assert property (@(posedge clk) force_trap && reset_n |=> force_trap);

endmodule

`default_nettype wire

// File: rtl/tk1_led_gpio.sv
// tk1 LED and GPIO pin logic
// Blinks red on a CPU trap, otherwise shows the LED register, and
// synchronises the two GPIO inputs

`timescale 1ns/1ps
`default_nettype none

module tk1_led_gpio (
  input  wire        clk,
  input  wire        reset_n,
  input  wire        cpu_trap,
  input  wire [2:0]  led_value,
  input  wire        gpio1,
  input  wire        gpio2,
  input  wire [1:0]  gpio_out,
  output logic       led_r,
  output logic       led_g,
  output logic       led_b,
  output logic       gpio3,
  output logic       gpio4,
  output logic [1:0] gpio_in
);

  logic [tk1_pkg::TRAP_BLINK_BITS-1:0] blink_ctr;
  logic [2:0] trap_led_reg;
  logic [2:0] muxed_led;
  logic [1:0] gpio1_sync;
  logic [1:0] gpio2_sync;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      blink_ctr    <= '0;
      trap_led_reg <= 3'b000;
      gpio1_sync   <= 2'b00;
      gpio2_sync   <= 2'b00;
    end else begin
      blink_ctr <= blink_ctr + 1'b1;
      // Toggle red on every counter wrap
      if (blink_ctr == '0) begin
        trap_led_reg[tk1_pkg::LED_R_BIT] <= ~trap_led_reg[tk1_pkg::LED_R_BIT];
      end
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};
    end
  end

  assign muxed_led = cpu_trap ? trap_led_reg : led_value;

  assign led_r   = muxed_led[tk1_pkg::LED_R_BIT];
  assign led_g   = muxed_led[tk1_pkg::LED_G_BIT];
  assign led_b   = muxed_led[tk1_pkg::LED_B_BIT];
  assign gpio_in = {gpio2_sync[1], gpio1_sync[1]};
  assign gpio3   = gpio_out[0];
  assign gpio4   = gpio_out[1];

endmodule

`default_nettype wire

// File: rtl/tk1_top.sv
// tk1 control core top level
// Register bank, CPU monitor and LED/GPIO pin logic on the core bus

`timescale 1ns/1ps
`default_nettype none

module tk1_top (
  input  wire        clk,
  input  wire        reset_n,
  input  wire        cs,
  input  wire        we,
  input  wire [7:0]  address,
  input  wire [31:0] write_data,
  output logic [31:0] read_data,
  output logic       ready,
  input  wire        cpu_trap,
  input  wire        cpu_valid,
  input  wire        cpu_instr,
  input  wire [31:0] cpu_addr,
  output logic       system_mode,
  output logic       force_trap,
  output logic       system_reset,
  output logic       led_r,
  output logic       led_g,
  output logic       led_b,
  input  wire        gpio1,
  input  wire        gpio2,
  output logic       gpio3,
  output logic       gpio4
);

  tk1_pkg::tk1_bus_req_t     bus_req;
  tk1_pkg::tk1_reg_sel_t     reg_sel;
  tk1_pkg::tk1_cpu_access_t  cpu_access;
  tk1_pkg::tk1_exec_window_t exec_window;
  logic [31:0] syscall_addr;
  logic [2:0]  led_value;
  logic [1:0]  gpio_out;
  logic [1:0]  gpio_in;

  assign bus_req    = '{cs: cs, we: we, address: address, write_data: write_data};
  assign cpu_access = '{valid: cpu_valid, instr: cpu_instr, addr: cpu_addr};

  tk1_addr_decode u_decode (
    .bus_req (bus_req),
    .reg_sel (reg_sel)
  );

  tk1_ctrl_regs u_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .bus_req      (bus_req),
    .reg_sel      (reg_sel),
    .system_mode  (system_mode),
    .gpio_in      (gpio_in),
    .read_data    (read_data),
    .ready        (ready),
    .exec_window  (exec_window),
    .syscall_addr (syscall_addr),
    .led_value    (led_value),
    .gpio_out     (gpio_out),
    .system_reset (system_reset)
  );

  tk1_cpu_monitor u_monitor (
    .clk          (clk),
    .reset_n      (reset_n),
    .cpu_access   (cpu_access),
    .exec_window  (exec_window),
    .syscall_addr (syscall_addr),
    .system_mode  (system_mode),
    .force_trap   (force_trap)
  );

  tk1_led_gpio u_led_gpio (
    .clk       (clk),
    .reset_n   (reset_n),
    .cpu_trap  (cpu_trap),
    .led_value (led_value),
    .gpio1     (gpio1),
    .gpio2     (gpio2),
    .gpio_out  (gpio_out),
    .led_r     (led_r),
    .led_g     (led_g),
    .led_b     (led_b),
    .gpio3     (gpio3),
    .gpio4     (gpio4),
    .gpio_in   (gpio_in)
  );

endmodule

`default_nettype wire

// File: tests/tb_tk1.sv
// tk1 control core testbench
// Directed tests for the identity words, register bank, system mode,
// CPU monitor traps and the trap-blink LED override

`timescale 1ns/1ps
`default_nettype none

module tb_tk1;

  logic        clk;
  logic        reset_n;
  logic        cs;
  logic        we;
  logic [7:0]  address;
  logic [31:0] write_data;
  logic        cpu_trap;
  logic        cpu_valid;
  logic        cpu_instr;
  logic [31:0] cpu_addr;
  logic        gpio1;
  logic        gpio2;
  wire  [31:0] read_data;
  wire         ready;
  wire         system_mode;
  wire         force_trap;
  wire         system_reset;
  wire         led_r;
  wire         led_g;
  wire         led_b;
  wire         gpio3;
  wire         gpio4;

  int          checks;
  int          errors;
  logic [15:0] lfsr_state;

  tk1_top uut (
    .clk          (clk),
    .reset_n      (reset_n),
    .cs           (cs),
    .we           (we),
    .address      (address),
    .write_data   (write_data),
    .read_data    (read_data),
    .ready        (ready),
    .cpu_trap     (cpu_trap),
    .cpu_valid    (cpu_valid),
    .cpu_instr    (cpu_instr),
    .cpu_addr     (cpu_addr),
    .system_mode  (system_mode),
    .force_trap   (force_trap),
    .system_reset (system_reset),
    .led_r        (led_r),
    .led_g        (led_g),
    .led_b        (led_b),
    .gpio1        (gpio1),
    .gpio2        (gpio2),
    .gpio3        (gpio3),
    .gpio4        (gpio4)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Stops a stuck run
  initial begin
    repeat (5000) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    $display("Verification failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output logic [31:0] word);
    word = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word = {word[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic flag_value(input string name);
    if (name == "system_reset") begin
      return system_reset;
    end else if (name == "system_mode") begin
      return system_mode;
    end
    return force_trap;
  endfunction

  // Counts falling edges until the flag reaches the level
  task automatic wait_level(input string name, input logic level, input int max_cycles,
                            output int cycles);
    cycles = 0;
    @(negedge clk);
    cycles = 1;
    while (flag_value(name) !== level && cycles < max_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (flag_value(name) !== level) begin
      errors++;
      $display("Timed out waiting for %s to reach %0b", name, level);
    end
  endtask

  task automatic reset_dut();
    @(posedge clk);
    reset_n   <= 1'b0;
    cs        <= 1'b0;
    we        <= 1'b0;
    cpu_trap  <= 1'b0;
    cpu_valid <= 1'b0;
    cpu_instr <= 1'b0;
    gpio1     <= 1'b0;
    gpio2     <= 1'b0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
  endtask

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    cs         <= 1'b1;
    we         <= 1'b1;
    address    <= addr;
    write_data <= data;
    @(posedge clk);
    cs <= 1'b0;
    we <= 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    cs      <= 1'b1;
    we      <= 1'b0;
    address <= addr;
    @(negedge clk);
    check_value("ready", ready, 1);
    data = read_data;
    @(posedge clk);
    cs <= 1'b0;
  endtask

  // Read issued in the cycle right after the write
  task automatic write_then_read(input logic [7:0] addr, input logic [31:0] data,
                                 input logic [31:0] exp);
    @(posedge clk);
    cs         <= 1'b1;
    we         <= 1'b1;
    address    <= addr;
    write_data <= data;
    @(posedge clk);
    we <= 1'b0;
    @(negedge clk);
    check_value("read_data", read_data, exp);
    @(posedge clk);
    cs <= 1'b0;
  endtask

  task automatic cpu_access(input logic instr, input logic [31:0] addr);
    @(posedge clk);
    cpu_valid <= 1'b1;
    cpu_instr <= instr;
    cpu_addr  <= addr;
    @(posedge clk);
    cpu_valid <= 1'b0;
    cpu_instr <= 1'b0;
  endtask

  // Input change and GPIO read start on the same edge
  task automatic gpio_input_step(input logic g1, input logic g2, input logic [3:0] exp);
    int cycles;
    @(posedge clk);
    cs      <= 1'b1;
    we      <= 1'b0;
    address <= 8'h0a;
    gpio1   <= g1;
    gpio2   <= g2;
    cycles = 0;
    @(negedge clk);
    while (read_data[1:0] !== exp[1:0] && cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    check_value("gpio readback", read_data[3:0], exp);
    check_value("gpio sync delay", cycles, 2);
    @(posedge clk);
    cs <= 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_identity();
    logic [31:0] rd;
    bus_read(8'h00, rd);
    check_value("name0", rd, "tk1 ");
    bus_read(8'h01, rd);
    check_value("name1", rd, "mkdf");
    bus_read(8'h02, rd);
    check_value("version", rd, 32'd5);
    bus_read(8'h05, rd);
    check_value("unmapped", rd, 32'h0);
    @(negedge clk);
    check_value("ready idle", ready, 0);
  endtask

  task automatic test_register_bank();
    logic [31:0] word;
    logic [31:0] rd;
    int          cycles;
    random_word(word);
    write_then_read(8'h0c, word, word);
    random_word(word);
    write_then_read(8'h0d, word, word);
    random_word(word);
    write_then_read(8'h12, word, word);
    for (int i = 0; i < 8; i++) begin
      random_word(word);
      write_then_read(8'h20 + i[7:0], word, word);
    end
    random_word(word);
    // Keep the LED value away from its reset value
    if (word[2:0] == 3'b110) begin
      word[2:0] = 3'b001;
    end
    bus_write(8'h09, word);
    @(negedge clk);
    check_value("led pins", {led_r, led_g, led_b}, word[2:0]);
    bus_read(8'h09, rd);
    check_value("led readback", rd, {29'h0, word[2:0]});
    bus_write(8'h0a, 32'h0000_000c);
    @(negedge clk);
    check_value("gpio4 gpio3", {gpio4, gpio3}, 2'b11);
    bus_write(8'h0a, 32'h0000_0004);
    @(negedge clk);
    check_value("gpio4 gpio3", {gpio4, gpio3}, 2'b01);
    gpio_input_step(1'b1, 1'b0, 4'b0101);
    gpio_input_step(1'b0, 1'b1, 4'b0110);
    bus_write(8'h70, 32'h1);
    wait_level("system_reset", 1'b1, 4, cycles);
    check_value("system_reset delay", cycles, 1);
    @(negedge clk);
    check_value("system_reset width", system_reset, 0);
  endtask

  task automatic test_system_mode();
    logic [31:0] start_word;
    logic [31:0] cdi_word;
    logic [31:0] word;
    logic [31:0] rd;
    int          cycles;
    random_word(start_word);
    bus_write(8'h0c, start_word);
    random_word(cdi_word);
    bus_write(8'h23, cdi_word);
    // Syscall entry sits inside ROM so it only lowers the mode
    bus_write(8'h12, 32'h0000_0100);
    cpu_access(1'b1, 32'h0000_2000);
    wait_level("system_mode", 1'b1, 4, cycles);
    check_value("system_mode rise delay", cycles, 1);
    bus_read(8'h08, rd);
    check_value("system_mode readback", rd, 32'hffff_ffff);
    random_word(word);
    write_then_read(8'h0c, word, start_word);
    random_word(word);
    write_then_read(8'h23, word, cdi_word);
    cpu_access(1'b1, 32'h0000_0100);
    wait_level("system_mode", 1'b0, 4, cycles);
    check_value("system_mode fall delay", cycles, 1);
  endtask

  task automatic test_security_monitor();
    logic [31:0] rd;
    int          cycles;
    cpu_access(1'b1, 32'hd000_0010);
    wait_level("force_trap", 1'b1, 4, cycles);
    check_value("fw ram trap delay", cycles, 1);
    repeat (4) begin
      @(negedge clk);
      check_value("force_trap sticky", force_trap, 1);
    end
    reset_dut();
    cpu_access(1'b0, 32'h4002_0000);
    wait_level("force_trap", 1'b1, 4, cycles);
    check_value("ram range trap delay", cycles, 1);
    reset_dut();
    bus_write(8'h61, 32'h0001_0000);
    bus_write(8'h62, 32'h0001_00ff);
    bus_write(8'h60, 32'h1);
    bus_write(8'h61, 32'h0000_0000);
    bus_write(8'h62, 32'hffff_ffff);
    bus_read(8'h60, rd);
    check_value("window enable", rd, 32'h1);
    bus_read(8'h61, rd);
    check_value("window first", rd, 32'h0001_0000);
    bus_read(8'h62, rd);
    check_value("window last", rd, 32'h0001_00ff);
    cpu_access(1'b0, 32'h0001_0010);
    @(negedge clk);
    check_value("window data access", force_trap, 0);
    cpu_access(1'b1, 32'h0001_0020);
    wait_level("force_trap", 1'b1, 4, cycles);
    check_value("window fetch trap delay", cycles, 1);
  endtask

  task automatic test_trap_led();
    repeat (2) @(posedge clk);
    cpu_trap <= 1'b1;
    @(negedge clk);
    check_value("trap led pins", {led_r, led_g, led_b}, 3'b100);
    @(posedge clk);
    cpu_trap <= 1'b0;
    @(negedge clk);
    check_value("led pins after trap", {led_r, led_g, led_b}, 3'b110);
  endtask

  initial begin
    checks     = 0;
    errors     = 0;
    lfsr_state = 16'd51;
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = 8'h00;
    write_data = 32'h0;
    cpu_trap   = 1'b0;
    cpu_valid  = 1'b0;
    cpu_instr  = 1'b0;
    cpu_addr   = 32'h0;
    gpio1      = 1'b0;
    gpio2      = 1'b0;

    reset_dut();
    test_identity();
    reset_dut();
    test_register_bank();
    reset_dut();
    test_system_mode();
    reset_dut();
    test_security_monitor();
    reset_dut();
    test_trap_led();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
rtl/tk1_pkg.sv
rtl/tk1_addr_decode.sv
rtl/tk1_ctrl_regs.sv
rtl/tk1_cpu_monitor.sv
rtl/tk1_led_gpio.sv
rtl/tk1_top.sv
tests/tb_tk1.sv

// File: Bender.yml
package:
  name: tk1

sources:
  # Package first, then leaf modules, then the top level
  - rtl/tk1_pkg.sv
  - rtl/tk1_addr_decode.sv
  - rtl/tk1_ctrl_regs.sv
  - rtl/tk1_cpu_monitor.sv
  - rtl/tk1_led_gpio.sv
  - rtl/tk1_top.sv
  - target: test
    files:
      - tests/tb_tk1.sv
